// ==== Bender.yml ====
package:
  name: sdram_ctrl

sources:
  - verilog/sdram_pkg.sv
  - verilog/sdram_req_if.sv
  - verilog/refresh_timer.sv
  - verilog/request_arbiter.sv
  - verilog/command_sequencer.sv
  - verilog/read_capture.sv
  - verilog/sdram_ctrl.sv
  - target: test
    files:
      - tb/sdram_model.sv
      - tb/sdram_ctrl_assert.sv
      - tb/tb_sdram_ctrl.sv

// ==== list.f ====
verilog/sdram_pkg.sv
verilog/sdram_req_if.sv
verilog/refresh_timer.sv
verilog/request_arbiter.sv
verilog/command_sequencer.sv
verilog/read_capture.sv
verilog/sdram_ctrl.sv
tb/sdram_model.sv
tb/sdram_ctrl_assert.sv
tb/tb_sdram_ctrl.sv

// ==== tb/sdram_ctrl_assert.sv ====
// sdram_ctrl_assert
// protocol rules on the controller's device pins, bound into sdram_ctrl

module sdram_ctrl_assert (
	input logic                clk,
	input logic                rst,
	input logic                ras_n,
	input logic                cas_n,
	input logic                we_n,
	input logic                cs_n,
	input sdram_pkg::sd_addr_t a,
	input logic                dq_oe
);
	timeunit 1ns;
	timeprecision 100ps;
	import sdram_pkg::*;

	sd_cmd_t     cmd;
	logic        seen_pre;  // first precharge has gone out
	logic        row_open;
	logic [3:0]  nop_left;  // nops still owed after auto refresh
	int unsigned fail_count = 0;

	assign cmd = sd_cmd_t'({ras_n, cas_n, we_n});

	always_ff @(posedge clk) begin
		if (rst) begin
			seen_pre <= 1'b0;
			row_open <= 1'b0;
			nop_left <= '0;
		end else begin
			if (!cs_n && cmd == PRECHARGE)
				seen_pre <= 1'b1;
			if (!cs_n && cmd == ACTIVE)
				row_open <= 1'b1;
			else if (!cs_n && (cmd == PRECHARGE || ((cmd == READ || cmd == WRITE) && a[10])))
				row_open <= 1'b0; // explicit or auto precharge
			if (!cs_n && cmd == AUTO_REFRESH)
				nop_left <= 4'(trfc_cycles);
			else if (nop_left != '0)
				nop_left <= nop_left - 1'b1;
		end
	end

	dq_only_in_write: assert property (@(posedge clk) disable iff (rst)
		dq_oe |-> cmd == WRITE)
		else begin
			fail_count++;
			$error("dq driven outside a WRITE cycle");
		end

	deselect_before_precharge: assert property (@(posedge clk) disable iff (rst)
		(!seen_pre && cmd != PRECHARGE) |-> cs_n)
		else begin
			fail_count++;
			$error("cs_n low before the first PRECHARGE");
		end

	column_needs_open_row: assert property (@(posedge clk) disable iff (rst)
		(!cs_n && (cmd == READ || cmd == WRITE)) |-> row_open)
		else begin
			fail_count++;
			$error("READ or WRITE without an open row");
		end

	refresh_recovery: assert property (@(posedge clk) disable iff (rst)
		(nop_left != '0) |-> cmd == NOP)
		else begin
			fail_count++;
			$error("command issued during the refresh recovery time");
		end

endmodule

bind sdram_ctrl sdram_ctrl_assert sdram_ctrl_assert_i (
	.clk, .rst, .ras_n, .cas_n, .we_n, .cs_n, .a, .dq_oe
);

// ==== tb/sdram_model.sv ====
// sdram_model
// behavioral SDR SDRAM for simulation; decodes the command pins, keeps the
// open row per bank, stores halfwords under DQM and answers burst-2 reads
// at CAS latency 2

module sdram_model (
	input  logic                  clk,
	input  logic                  cs_n,
	input  logic                  ras_n,
	input  logic                  cas_n,
	input  logic                  we_n,
	input  sdram_pkg::sd_bank_t   ba,
	input  sdram_pkg::sd_addr_t   a,
	input  logic                  dqm_h,
	input  logic                  dqm_l,
	inout  wire sdram_pkg::half_t dq
);
	timeunit 1ns;
	timeprecision 100ps;
	import sdram_pkg::*;

	logic [12:0] open_row [4];
	half_t       mem [logic [23:0]];  // key is {bank, row, column}
	logic [1:0]  rd_v = 2'b00;        // read beats in flight
	logic [23:0] rd_loc [2];
	logic        drv_en = 1'b0;
	half_t       drv_data;
	half_t       merged;
	sd_cmd_t     cmd;
	logic [23:0] loc;

	assign cmd = sd_cmd_t'({ras_n, cas_n, we_n});
	assign loc = {ba, open_row[ba], a[8:0]};
	assign dq = drv_en ? drv_data : 'z;

	// unwritten locations return a pattern built from the whole address
	function automatic half_t fetch(input logic [23:0] key);
		if (mem.exists(key))
			return mem[key];
		return half_t'(key[15:0] ^ {key[23:16], 8'h00} ^ 16'h5a5a);
	endfunction

	always @(posedge clk) begin
		if (!cs_n && cmd == ACTIVE)
			open_row[ba] <= a;

		if (!cs_n && cmd == WRITE) begin
			merged = fetch(loc);
			if (!dqm_l)
				merged[7:0] = dq[7:0];
			if (!dqm_h)
				merged[15:8] = dq[15:8];
			mem[loc] = merged;
		end

		// ----------------------------------------------------------------------
		// read pipeline, first beat driven one cycle after the command edge
		// ----------------------------------------------------------------------
		rd_v <= {rd_v[0], !cs_n && cmd == READ};
		rd_loc[0] <= loc;
		rd_loc[1] <= {rd_loc[0][23:1], ~rd_loc[0][0]}; // burst of 2 wraps
		drv_en <= rd_v[0] || rd_v[1];
		if (rd_v[0])
			drv_data <= fetch(rd_loc[0]);
		else if (rd_v[1])
			drv_data <= fetch(rd_loc[1]);
	end

endmodule

// ==== tb/tb_sdram_ctrl.sv ====
// tb_sdram_ctrl
// directed tests of the two-channel SDRAM controller against a behavioral
// SDRAM, with a scoreboard of written words

module tb_sdram_ctrl;
	timeunit 1ns;
	timeprecision 100ps;
	import sdram_pkg::*;

	localparam int startup_cycles = 200;
	localparam int refresh_interval = 300;
	// startup and init about 250, refresh test about 620, random traffic
	// 40 accesses of up to 20 cycles, the rest about 300; doubled for margin
	localparam int timeout_cycles = 4000;
	localparam int ready_limit = 100;
	// single-location writes, cl 2, sequential, burst length 2
	localparam sd_addr_t mode_expected = 13'h0221;

	logic       clk = 1'b0;
	logic       rst;
	logic       req_a;
	logic       write_a;
	host_addr_t addr_a;
	word_t      wdata_a;
	be_t        be_a;
	word_t      rdata_a;
	logic       ready_a;
	logic       req_b;
	logic       write_b;
	host_addr_t addr_b;
	word_t      wdata_b;
	be_t        be_b;
	word_t      rdata_b;
	logic       ready_b;
	logic       refresh_force;
	logic       ras_n;
	logic       cas_n;
	logic       we_n;
	logic       cs_n;
	logic       cke;
	sd_bank_t   ba;
	sd_addr_t   a;
	logic       dqm_h;
	logic       dqm_l;
	wire half_t dq;

	word_t       sb [host_addr_t]; // expected contents per word address
	logic [31:0] rng_state = 32'hd4f5_3646;
	int          cycle_count = 0;

	sdram_ctrl #(
		.startup_cycles  (startup_cycles),
		.refresh_interval(refresh_interval)
	) sdram_ctrl_i (
		.clk, .rst, .req_a, .write_a, .addr_a, .wdata_a, .be_a, .rdata_a, .ready_a,
		.req_b, .write_b, .addr_b, .wdata_b, .be_b, .rdata_b, .ready_b,
		.refresh_force, .ras_n, .cas_n, .we_n, .cs_n, .cke, .ba, .a, .dqm_h, .dqm_l, .dq
	);

	sdram_model sdram_model_i (
		.clk, .cs_n, .ras_n, .cas_n, .we_n, .ba, .a, .dqm_h, .dqm_l, .dq
	);

	initial begin
		forever #10 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// failure handling, timeout and compare tasks
	// ----------------------------------------------------------------------
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	function automatic int unsigned protocol_errors();
		return sdram_ctrl_i.sdram_ctrl_assert_i.fail_count;
	endfunction

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			fail_run("timeout, the tests did not finish within the cycle limit");
		else if (protocol_errors() != 0)
			fail_run("a protocol assertion on the device pins failed");
	end

	task automatic check_word(input string test, input word_t exp, input word_t act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s expected %h actual %h", test, exp, act));
	endtask

	task automatic check_cmd(input string test, input sd_cmd_t exp, input sd_cmd_t act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s expected %s actual %s (%b)", test, exp.name(),
				act.name(), act));
	endtask

	task automatic check_addr(input string test, input sd_addr_t exp, input sd_addr_t act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s expected %h actual %h", test, exp, act));
	endtask

	task automatic check_bank(input string test, input sd_bank_t exp, input sd_bank_t act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s expected %h actual %h", test, exp, act));
	endtask

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t nw, input be_t be);
		word_t res;
		res = old;
		for (int i = 0; i < 4; i++)
			if (be[i])
				res[8*i +: 8] = nw[8*i +: 8];
		return res;
	endfunction

	function automatic sd_cmd_t bus_cmd();
		return sd_cmd_t'({ras_n, cas_n, we_n});
	endfunction

	task automatic pulse_req(input chan_t ch, input logic wr, input host_addr_t ad,
			input word_t wd, input be_t be);
		if (ch == 1'b0) begin
			req_a = 1'b1;
			write_a = wr;
			addr_a = ad;
			wdata_a = wd;
			be_a = be;
		end else begin
			req_b = 1'b1;
			write_b = wr;
			addr_b = ad;
			wdata_b = wd;
			be_b = be;
		end
	endtask

	task automatic wait_ready(input chan_t ch, output word_t rd);
		int n;
		n = 0;
		while ((ch == 1'b0 ? ready_a : ready_b) !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > ready_limit)
				fail_run($sformatf("no ready on channel %0d within %0d cycles", ch, ready_limit));
		end
		rd = (ch == 1'b0) ? rdata_a : rdata_b;
	endtask

	task automatic wait_cmd(input string test, input sd_cmd_t c, input int limit);
		int n;
		n = 0;
		while (cs_n || bus_cmd() != c) begin
			@(negedge clk);
			n++;
			if (n > limit)
				fail_run($sformatf("%s: no %s within %0d cycles", test, c.name(), limit));
		end
	endtask

	// one access; the row activate must carry the bank and row fields of the address
	task automatic access(input string test, input chan_t ch, input logic wr,
			input host_addr_t ad, input word_t wd, input be_t be, output word_t rd);
		@(negedge clk);
		pulse_req(ch, wr, ad, wd, be);
		@(negedge clk);
		req_a = 1'b0;
		req_b = 1'b0;
		wait_cmd(test, ACTIVE, ready_limit);
		check_bank(test, ad[22:21], ba);
		check_addr(test, ad[20:8], a);
		wait_ready(ch, rd);
	endtask

	task automatic write_word(input string test, input chan_t ch, input host_addr_t ad,
			input word_t wd, input be_t be);
		word_t rd;
		access(test, ch, 1'b1, ad, wd, be, rd);
		sb[ad] = merge_bytes(sb.exists(ad) ? sb[ad] : '0, wd, be);
	endtask

	task automatic read_check(input string test, input chan_t ch, input host_addr_t ad);
		word_t rd;
		access(test, ch, 1'b0, ad, '0, '0, rd);
		check_word(test, sb[ad], rd);
	endtask

	// both channels complete; ready_a must come strictly before ready_b
	task automatic wait_both(input string test, output word_t rd_a, output word_t rd_b);
		int n;
		int t_a;
		int t_b;
		n = 0;
		t_a = -1;
		t_b = -1;
		while (t_a < 0 || t_b < 0) begin
			@(negedge clk);
			n++;
			if (n > 2 * ready_limit)
				fail_run($sformatf("%s: a channel never signalled ready", test));
			if (ready_a === 1'b1) begin
				t_a = n;
				rd_a = rdata_a;
			end
			if (ready_b === 1'b1) begin
				t_b = n;
				rd_b = rdata_b;
			end
		end
		if (t_b <= t_a)
			fail_run($sformatf("%s: ready_b did not follow ready_a", test));
	endtask

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------
	task automatic init_sequence();
		sd_cmd_t expected [4];
		sd_cmd_t got;
		int      n;
		expected = '{PRECHARGE, AUTO_REFRESH, AUTO_REFRESH, LOAD_MODE};
		for (int i = 0; i < 4; i++) begin
			got = NOP;
			n = 0;
			while (got == NOP) begin
				@(negedge clk);
				n++;
				if (n > startup_cycles + 50)
					fail_run("init_sequence: expected init command never appeared");
				if (!cs_n)
					got = bus_cmd();
			end
			check_cmd("init_sequence", expected[i], got);
			if (i == 3)
				check_addr("init_sequence", mode_expected, a);
		end
		if (cke !== 1'b1)
			fail_run("init_sequence: cke is not held high");
	endtask

	task automatic write_read_each();
		write_word("write_read_each", 1'b0, 23'h00_0104, 32'hcafe_0a0a, 4'hf);
		read_check("write_read_each", 1'b0, 23'h00_0104);
		write_word("write_read_each", 1'b1, 23'h7f_ff7f, 32'h1357_9bdf, 4'hf);
		read_check("write_read_each", 1'b1, 23'h7f_ff7f);
		read_check("write_read_each", 1'b1, 23'h00_0104); // a's word seen from b
	endtask

	task automatic byte_enables();
		write_word("byte_enables", 1'b0, 23'h35_5a21, 32'h1122_3344, 4'hf);
		write_word("byte_enables", 1'b1, 23'h35_5a21, 32'haabb_ccdd, 4'b0101);
		read_check("byte_enables", 1'b0, 23'h35_5a21);
		write_word("byte_enables", 1'b0, 23'h35_5a21, 32'h5566_7788, 4'b1000);
		write_word("byte_enables", 1'b1, 23'h35_5a21, 32'h99aa_bbcc, 4'b0010);
		read_check("byte_enables", 1'b1, 23'h35_5a21);
	endtask

	task automatic both_channels();
		word_t rd_a;
		word_t rd_b;
		@(negedge clk);
		pulse_req(1'b0, 1'b1, 23'h41_0a10, 32'h0f1e_2d3c, 4'hf);
		pulse_req(1'b1, 1'b1, 23'h02_33f0, 32'h4b5a_6978, 4'hf);
		@(negedge clk);
		req_a = 1'b0;
		req_b = 1'b0;
		wait_both("both_channels", rd_a, rd_b);
		sb[23'h41_0a10] = 32'h0f1e_2d3c;
		sb[23'h02_33f0] = 32'h4b5a_6978;

		@(negedge clk);
		pulse_req(1'b0, 1'b0, 23'h02_33f0, '0, '0); // each reads the other's word
		pulse_req(1'b1, 1'b0, 23'h41_0a10, '0, '0);
		@(negedge clk);
		req_a = 1'b0;
		req_b = 1'b0;
		wait_both("both_channels", rd_a, rd_b);
		check_word("both_channels", sb[23'h02_33f0], rd_a);
		check_word("both_channels", sb[23'h41_0a10], rd_b);
	endtask

	task automatic refresh();
		wait_cmd("refresh", AUTO_REFRESH, 2 * refresh_interval);
		@(negedge clk);
		refresh_force = 1'b1;
		@(negedge clk);
		wait_cmd("refresh", AUTO_REFRESH, 20);
		refresh_force = 1'b0;
	endtask

	task automatic random_traffic();
		host_addr_t  pool [8];
		logic [31:0] r;
		host_addr_t  ad;
		for (int i = 0; i < 8; i++)
			pool[i] = host_addr_t'(next_rand());
		for (int k = 0; k < 40; k++) begin
			r = next_rand();
			ad = pool[r[3:1]];
			if (!sb.exists(ad)) // first touch writes it all
				write_word("random_traffic", r[0], ad, next_rand(), 4'hf);
			else if (r[8])
				write_word("random_traffic", r[0], ad, next_rand(), r[7:4]);
			else
				read_check("random_traffic", r[0], ad);
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		rst = 1'b1;
		req_a = 1'b0;
		write_a = 1'b0;
		addr_a = '0;
		wdata_a = '0;
		be_a = '0;
		req_b = 1'b0;
		write_b = 1'b0;
		addr_b = '0;
		wdata_b = '0;
		be_b = '0;
		refresh_force = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		init_sequence();
		write_read_each();
		byte_enables();
		both_channels();
		refresh();
		random_traffic();
		repeat (20) @(negedge clk);

		if (protocol_errors() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			fail_run("a protocol assertion on the device pins failed");
		end
	end

endmodule

// ==== verilog/command_sequencer.sv ====
// command_sequencer
// issues the device commands: power-up init, auto refresh, and per host
// request a row activate followed by a burst-2 read or two single writes,
// both closing the row with auto precharge

module command_sequencer (
	input  logic                clk,
	input  logic                rst,
	sdram_req_if.sequencer      req,
	input  logic                startup_done,
	input  logic                refresh_due,
	output logic                refresh_ack,
	output sdram_pkg::sd_cmd_t  cmd,
	output logic                cs_n,
	output sdram_pkg::sd_bank_t ba,
	output sdram_pkg::sd_addr_t a,
	output logic [1:0]          dqm,
	output sdram_pkg::half_t    dq_out,
	output logic                dq_oe,
	output logic                rd_issue,
	output sdram_pkg::chan_t    rd_chan,
	output logic                wr_done,
	output sdram_pkg::chan_t    wr_chan
);
	import sdram_pkg::*;

	localparam logic [3:0] gap_load = 4'(init_gap - 1);
	localparam logic [3:0] trfc_load = 4'(trfc_cycles - 1);
	localparam logic [3:0] trp_load = 4'(trp_cycles - 1);
	localparam logic [3:0] read_tail = 4'd3; // idle four cycles after READ

	seq_state_t state;
	logic [3:0] wait_cnt;
	logic [1:0] init_step;

	// request being served
	host_addr_t cur_addr;
	word_t      cur_wdata;
	be_t        cur_be;
	logic       cur_write;
	chan_t      cur_chan;

	assign req.take = (state == ST_IDLE) && !refresh_due && req.valid;

	assign rd_chan = cur_chan;
	assign wr_chan = cur_chan;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_STARTUP;
			wait_cnt <= '0;
			init_step <= '0;
			cmd <= NOP;
			cs_n <= 1'b1; // deselected until the first precharge
			ba <= '0;
			a <= '0;
			dqm <= 2'b00;
			dq_oe <= 1'b0;
			rd_issue <= 1'b0;
			wr_done <= 1'b0;
			refresh_ack <= 1'b0;
		end else begin
			cmd <= NOP;
			dqm <= 2'b00;
			dq_oe <= 1'b0;
			rd_issue <= 1'b0;
			wr_done <= 1'b0;
			refresh_ack <= 1'b0;

			case (state)
				// ------------------------------------------------------------
				// power-up
				// ------------------------------------------------------------
				ST_STARTUP: begin
					if (startup_done) begin
						cmd <= PRECHARGE;
						cs_n <= 1'b0;
						ba <= '0;
						a <= 13'h0400; // a10 high, all banks
						wait_cnt <= gap_load;
						init_step <= '0;
						state <= ST_INIT;
					end
				end

				ST_INIT: begin
					if (wait_cnt != '0) begin
						wait_cnt <= wait_cnt - 1'b1;
					end else begin
						wait_cnt <= gap_load;
						init_step <= init_step + 1'b1;
						case (init_step)
							2'd0, 2'd1: cmd <= AUTO_REFRESH;
							2'd2: begin
								cmd <= LOAD_MODE;
								a <= mode_word;
							end
							default: state <= ST_IDLE;
						endcase
					end
				end

				// ------------------------------------------------------------
				// normal operation
				// ------------------------------------------------------------
				ST_IDLE: begin
					if (refresh_due) begin // refresh beats a waiting request
						cmd <= AUTO_REFRESH;
						refresh_ack <= 1'b1;
						wait_cnt <= trfc_load;
						state <= ST_WAIT;
					end else if (req.valid) begin
						cmd <= ACTIVE;
						ba <= req.addr[22:21];
						a <= req.addr[20:8]; // row
						cur_addr <= req.addr;
						cur_wdata <= req.wdata;
						cur_be <= req.be;
						cur_write <= req.write;
						cur_chan <= req.chan;
						state <= ST_ACT_WAIT;
					end
				end

				ST_ACT_WAIT: state <= ST_RW1;

				ST_RW1: begin
					if (cur_write) begin
						cmd <= WRITE;
						a <= {4'b0000, cur_addr[7:0], 1'b0}; // no precharge yet
						dq_out <= cur_wdata[15:0];
						dq_oe <= 1'b1;
						dqm <= ~cur_be[1:0];
						state <= ST_WR2;
					end else begin
						cmd <= READ;
						a <= {2'b00, 1'b1, 1'b0, cur_addr[7:0], 1'b0}; // auto precharge
						rd_issue <= 1'b1;
						wait_cnt <= read_tail;
						state <= ST_WAIT;
					end
				end

				ST_WR2: begin
					cmd <= WRITE;
					a <= {2'b00, 1'b1, 1'b0, cur_addr[7:0], 1'b1}; // odd column, precharge
					dq_out <= cur_wdata[31:16];
					dq_oe <= 1'b1;
					dqm <= ~cur_be[3:2];
					wr_done <= 1'b1;
					wait_cnt <= trp_load;
					state <= ST_WAIT;
				end

				ST_WAIT: begin
					if (wait_cnt == '0)
						state <= ST_IDLE;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end

				default: state <= ST_STARTUP;
			endcase
		end
	end

endmodule

// ==== verilog/read_capture.sv ====
// read_capture
// tracks issued reads through the CAS latency and assembles the two
// returning halfwords into the tagged channel's 32-bit word

module read_capture (
	input  logic              clk,
	input  logic              rst,
	input  sdram_pkg::half_t  dq_in,
	input  logic              rd_issue,
	input  sdram_pkg::chan_t  rd_chan,
	output sdram_pkg::word_t  rdata_a,
	output sdram_pkg::word_t  rdata_b,
	output logic              ready_rd_a,
	output logic              ready_rd_b
);
	import sdram_pkg::*;

	localparam int depth = cas_latency + 3;
	localparam int lo_stage = cas_latency;     // low half sits in dq_reg
	localparam int hi_stage = cas_latency + 1;

	half_t            dq_reg;
	logic [depth-1:0] stage_v;
	chan_t            stage_ch [depth];

	always_ff @(posedge clk) begin
		dq_reg <= dq_in;
	end

	always_ff @(posedge clk) begin
		if (rst)
			stage_v <= '0;
		else
			stage_v <= {stage_v[depth-2:0], rd_issue};
	end

	always_ff @(posedge clk) begin
		stage_ch[0] <= rd_chan;
		for (int i = 1; i < depth; i++)
			stage_ch[i] <= stage_ch[i-1];
	end

	always_ff @(posedge clk) begin
		if (stage_v[lo_stage]) begin
			if (stage_ch[lo_stage] == 1'b0)
				rdata_a[15:0] <= dq_reg;
			else
				rdata_b[15:0] <= dq_reg;
		end
		if (stage_v[hi_stage]) begin
			if (stage_ch[hi_stage] == 1'b0)
				rdata_a[31:16] <= dq_reg;
			else
				rdata_b[31:16] <= dq_reg;
		end
	end

	// word complete one cycle after the high half lands
	assign ready_rd_a = stage_v[depth-1] && (stage_ch[depth-1] == 1'b0);
	assign ready_rd_b = stage_v[depth-1] && (stage_ch[depth-1] == 1'b1);

endmodule

// ==== verilog/refresh_timer.sv ====
// refresh_timer
// power-up delay, then cycle count since the last auto refresh;
// raises refresh_due on an elapsed interval or a forced refresh edge

module refresh_timer #(
	parameter int startup_cycles = 12100,
	parameter int refresh_interval = 780
) (
	input  logic clk,
	input  logic rst,
	input  logic refresh_force,
	input  logic refresh_ack,
	output logic startup_done,
	output logic refresh_due
);

	localparam int st_w = $clog2(startup_cycles + 1);
	localparam int rc_w = $clog2(refresh_interval + 1) + 2; // headroom while refresh waits

	logic [st_w-1:0] startup_cnt;
	logic [rc_w-1:0] refresh_cnt;
	logic            force_q;
	logic            force_req;
	logic            interval_over;

	assign interval_over = refresh_cnt > rc_w'(refresh_interval);
	assign refresh_due = startup_done && (interval_over || force_req);

	always_ff @(posedge clk) begin
		if (rst) begin
			startup_cnt <= st_w'(startup_cycles - 1);
			startup_done <= 1'b0;
			refresh_cnt <= '0;
			force_q <= 1'b0;
			force_req <= 1'b0;
		end else begin
			force_q <= refresh_force;
			if (refresh_ack)
				force_req <= 1'b0;
			if (refresh_force && !force_q) // a new edge wins over the ack
				force_req <= 1'b1;

			if (!startup_done) begin
				if (startup_cnt == '0)
					startup_done <= 1'b1;
				else
					startup_cnt <= startup_cnt - 1'b1;
			end else if (refresh_ack) begin
				// keep the overshoot so late refreshes catch up
				if (interval_over)
					refresh_cnt <= refresh_cnt - rc_w'(refresh_interval) + 1'b1;
				else
					refresh_cnt <= '0; // forced refresh restarts the interval
			end else begin
				refresh_cnt <= refresh_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== verilog/request_arbiter.sv ====
// request_arbiter
// latches the request pulses of host channels a and b and presents one
// pending request at a time, channel a first

module request_arbiter (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 req_a,
	input  logic                 req_b,
	input  logic                 write_a,
	input  logic                 write_b,
	input  sdram_pkg::host_addr_t addr_a,
	input  sdram_pkg::host_addr_t addr_b,
	input  sdram_pkg::word_t     wdata_a,
	input  sdram_pkg::word_t     wdata_b,
	input  sdram_pkg::be_t       be_a,
	input  sdram_pkg::be_t       be_b,
	sdram_req_if.arbiter         req
);
	import sdram_pkg::*;

	logic [1:0] req_in;
	logic [1:0] write_in;
	host_addr_t addr_in [2];
	word_t      wdata_in [2];
	be_t        be_in [2];

	logic [1:0] pending;
	logic [1:0] cap_write;
	host_addr_t cap_addr [2];
	word_t      cap_wdata [2];
	be_t        cap_be [2];
	chan_t      sel;

	// index 0 is channel a, index 1 is channel b
	assign req_in = {req_b, req_a};
	assign write_in = {write_b, write_a};
	assign addr_in[0] = addr_a;
	assign addr_in[1] = addr_b;
	assign wdata_in[0] = wdata_a;
	assign wdata_in[1] = wdata_b;
	assign be_in[0] = be_a;
	assign be_in[1] = be_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (req_in[i])
					pending[i] <= 1'b1;
				else if (req.take && sel == chan_t'(i))
					pending[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (req_in[i]) begin
				cap_write[i] <= write_in[i];
				cap_addr[i] <= addr_in[i];
				cap_wdata[i] <= wdata_in[i];
				cap_be[i] <= be_in[i];
			end
		end
	end

	assign sel = pending[0] ? 1'b0 : 1'b1; // fixed priority, a wins

	assign req.valid = |pending;
	assign req.chan = sel;
	assign req.addr = cap_addr[sel];
	assign req.wdata = cap_wdata[sel];
	assign req.be = cap_be[sel];
	assign req.write = cap_write[sel];

endmodule

// ==== verilog/sdram_ctrl.sv ====
// sdram_ctrl
// two-channel controller for a 16-bit SDR SDRAM, 4 banks, 13 row and
// 9 column bits; channel a has priority over channel b

module sdram_ctrl #(
	parameter int startup_cycles = 12100,
	parameter int refresh_interval = 780
) (
	input  logic                  clk,
	input  logic                  rst,
	// host channel a
	input  logic                  req_a,
	input  logic                  write_a,
	input  sdram_pkg::host_addr_t addr_a,
	input  sdram_pkg::word_t      wdata_a,
	input  sdram_pkg::be_t        be_a,
	output sdram_pkg::word_t      rdata_a,
	output logic                  ready_a,
	// host channel b
	input  logic                  req_b,
	input  logic                  write_b,
	input  sdram_pkg::host_addr_t addr_b,
	input  sdram_pkg::word_t      wdata_b,
	input  sdram_pkg::be_t        be_b,
	output sdram_pkg::word_t      rdata_b,
	output logic                  ready_b,
	input  logic                  refresh_force,
	// device pins
	output logic                  ras_n,
	output logic                  cas_n,
	output logic                  we_n,
	output logic                  cs_n,
	output logic                  cke,
	output sdram_pkg::sd_bank_t   ba,
	output sdram_pkg::sd_addr_t   a,
	output logic                  dqm_h,
	output logic                  dqm_l,
	inout  wire sdram_pkg::half_t dq
);
	import sdram_pkg::*;

	logic    startup_done;
	logic    refresh_due;
	logic    refresh_ack;
	sd_cmd_t cmd;
	half_t   dq_out;
	logic    dq_oe;
	logic    rd_issue;
	chan_t   rd_chan;
	logic    wr_done;
	chan_t   wr_chan;
	logic    ready_rd_a;
	logic    ready_rd_b;

	sdram_req_if req_bus ();

	refresh_timer #(
		.startup_cycles  (startup_cycles),
		.refresh_interval(refresh_interval)
	) refresh_timer_i (
		.clk, .rst, .refresh_force, .refresh_ack, .startup_done, .refresh_due
	);

	request_arbiter request_arbiter_i (
		.clk, .rst, .req_a, .req_b, .write_a, .write_b, .addr_a, .addr_b,
		.wdata_a, .wdata_b, .be_a, .be_b, .req(req_bus.arbiter)
	);

	command_sequencer command_sequencer_i (
		.clk, .rst, .req(req_bus.sequencer), .startup_done, .refresh_due,
		.refresh_ack, .cmd, .cs_n, .ba, .a, .dqm({dqm_h, dqm_l}), .dq_out, .dq_oe,
		.rd_issue, .rd_chan, .wr_done, .wr_chan
	);

	read_capture read_capture_i (
		.clk, .rst, .dq_in(dq), .rd_issue, .rd_chan, .rdata_a, .rdata_b,
		.ready_rd_a, .ready_rd_b
	);

	assign dq = dq_oe ? dq_out : 'z;
	assign {ras_n, cas_n, we_n} = cmd;
	assign cke = 1'b1;

	// writes finish on the second WRITE, reads when the word is assembled
	assign ready_a = ready_rd_a || (wr_done && wr_chan == 1'b0);
	assign ready_b = ready_rd_b || (wr_done && wr_chan == 1'b1);

endmodule

// ==== verilog/sdram_pkg.sv ====
// sdram_pkg
// shared widths, device command codes, sequencer states and timing
// constants for the 16-bit SDR SDRAM controller

package sdram_pkg;

	// ----------------------------------------------------------------------
	// data and address types
	// ----------------------------------------------------------------------
	typedef logic [31:0] word_t;      // host data word
	typedef logic [15:0] half_t;      // device data word
	typedef logic [3:0]  be_t;        // byte enables, bit i for byte i
	typedef logic [22:0] host_addr_t; // bank(2) row(13) column word(8)
	typedef logic [12:0] sd_addr_t;
	typedef logic [1:0]  sd_bank_t;
	typedef logic        chan_t;      // 0 is channel a, 1 is channel b

	// {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		NOP          = 3'b111,
		ACTIVE       = 3'b011,
		READ         = 3'b101,
		WRITE        = 3'b100,
		PRECHARGE    = 3'b010,
		AUTO_REFRESH = 3'b001,
		LOAD_MODE    = 3'b000
	} sd_cmd_t;

	typedef enum logic [2:0] {
		ST_STARTUP,  // waiting for the power-up delay
		ST_INIT,     // precharge, two refreshes, mode load
		ST_IDLE,
		ST_ACT_WAIT, // row activate to column command gap
		ST_RW1,      // read, or low half of a write
		ST_WR2,      // high half of a write
		ST_WAIT      // counted nop cycles before idle
	} seq_state_t;

	// ----------------------------------------------------------------------
	// mode register and timing
	// ----------------------------------------------------------------------
	// single-location writes, standard op, cl 2, sequential, burst 2
	localparam sd_addr_t mode_word = {3'b000, 1'b1, 2'b00, 3'b010, 1'b0, 3'b001};

	localparam int cas_latency = 2;
	localparam int trp_cycles = 2;   // nops after the auto-precharging write
	localparam int trfc_cycles = 7;  // nops after auto refresh
	localparam int init_gap = 8;     // spacing of the init commands

endpackage

// ==== verilog/sdram_req_if.sv ====
// sdram_req_if
// one selected host request travelling from the arbiter to the sequencer;
// fields stay put while valid is high, take retires the request

interface sdram_req_if;
	import sdram_pkg::*;

	logic       valid;
	chan_t      chan;
	host_addr_t addr;
	word_t      wdata;
	be_t        be;
	logic       write;
	logic       take;  // one-cycle pulse from the sequencer

	modport arbiter (output valid, chan, addr, wdata, be, write, input take);
	modport sequencer (input valid, chan, addr, wdata, be, write, output take);

endinterface
